// ==== Bender.yml ====
package:
  name: mem_pipe

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpu_pkg.sv
      - logic/tlb.sv
      - logic/data_ram.sv
      - logic/cp0_regs.sv
      - logic/mem_stage.sv
      - logic/mem_pipe_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - sim/mem_pipe_assert.sv
      - sim/mem_checker.sv
      - sim/tb_mem_pipe.sv

// ==== logic/cp0_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cp0_regs (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire [`CPU_HW_INT_W-1:0]    hw_int_i,
    input  wire cpu_pkg::mem_wb_t      wb_i,
    output cpu_pkg::cp0_view_t         cp0_o
);

    logic exc_taken;

    assign exc_taken = (wb_i.exc_code != cpu_pkg::NONE);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cp0_o.status <= '0;
            cp0_o.cause  <= '0;
            cp0_o.epc    <= '0;
        end else begin
            if (exc_taken) begin
                // Exception capture, overrides any software write
                if (wb_i.in_delay) begin
                    cp0_o.epc <= wb_i.pc - `CPU_ADDR_W'(4);
                end else begin
                    cp0_o.epc <= wb_i.pc;
                end
                cp0_o.cause[31]  <= wb_i.in_delay;
                cp0_o.cause[6:2] <= wb_i.exc_code;
                cp0_o.status[1]  <= 1'b1;
            end else if (wb_i.cp0_we) begin
                case (wb_i.cp0_num)
                    `CPU_CP0_STATUS: begin
                        cp0_o.status <= wb_i.cp0_wdata;
                    end
                    `CPU_CP0_CAUSE: begin
                        // Only IP1..IP0, IV and WP are writable
                        cp0_o.cause[9:8] <= wb_i.cp0_wdata[9:8];
                        cp0_o.cause[22]  <= wb_i.cp0_wdata[22];
                        cp0_o.cause[23]  <= wb_i.cp0_wdata[23];
                    end
                    `CPU_CP0_EPC: begin
                        cp0_o.epc <= wb_i.cp0_wdata;
                    end
                    default: begin
                    end
                endcase
            end
            // Hardware interrupt pending bits, sampled every cycle
            cp0_o.cause[15:10] <= hw_int_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath widths
`define CPU_DATA_W 32
`define CPU_ADDR_W 32
`define CPU_REG_AW 5

// Address translation
`define CPU_TLB_ENTRIES 8
`define CPU_PAGE_BITS 12

// Data memory depth in words
`define CPU_RAM_WORDS 256

// Hardware interrupt lines
`define CPU_HW_INT_W 6

// CP0 register numbers
`define CPU_CP0_NUM_W 5
`define CPU_CP0_STATUS 5'd12
`define CPU_CP0_CAUSE 5'd13
`define CPU_CP0_EPC 5'd14

`endif

// ==== logic/cpu_pkg.sv ====
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

    typedef enum logic [3:0] {
        NOP = 4'd0,
        LB  = 4'd1,
        LBU = 4'd2,
        LH  = 4'd3,
        LHU = 4'd4,
        LW  = 4'd5,
        SB  = 4'd6,
        SH  = 4'd7,
        SW  = 4'd8
    } mem_op_e;

    typedef enum logic [4:0] {
        NONE = 5'h00,
        INT  = 5'h01,
        SYS  = 5'h08,
        RI   = 5'h0a,
        OV   = 5'h0c,
        TR   = 5'h0d,
        ADEL = 5'h0e,
        TLBL = 5'h0f
    } exc_code_e;

    // Bit positions in ex_mem_t.exc_flags, bit 4 is reserved
    localparam int EXF_SYS   = 0;
    localparam int EXF_RI    = 1;
    localparam int EXF_TR    = 2;
    localparam int EXF_OV    = 3;
    localparam int EXF_FETCH = 5;

    typedef struct packed {
        logic                        valid;
        logic [`CPU_REG_AW-1:0]      reg_waddr;
        logic                        reg_we;
        logic [`CPU_DATA_W-1:0]      reg_wdata;
        logic [`CPU_DATA_W-1:0]      hi;
        logic [`CPU_DATA_W-1:0]      lo;
        logic                        hilo_we;
        mem_op_e                     op;
        logic [`CPU_ADDR_W-1:0]      addr;
        logic [`CPU_DATA_W-1:0]      store_data;
        logic                        cp0_we;
        logic [`CPU_CP0_NUM_W-1:0]   cp0_num;
        logic [`CPU_DATA_W-1:0]      cp0_wdata;
        logic [5:0]                  exc_flags;
        logic                        in_delay;
        logic [`CPU_ADDR_W-1:0]      pc;
    } ex_mem_t;

    typedef struct packed {
        logic                        valid;
        logic [`CPU_REG_AW-1:0]      reg_waddr;
        logic                        reg_we;
        logic [`CPU_DATA_W-1:0]      reg_wdata;
        logic [`CPU_DATA_W-1:0]      hi;
        logic [`CPU_DATA_W-1:0]      lo;
        logic                        hilo_we;
        logic                        cp0_we;
        logic [`CPU_CP0_NUM_W-1:0]   cp0_num;
        logic [`CPU_DATA_W-1:0]      cp0_wdata;
        exc_code_e                   exc_code;
        logic [`CPU_ADDR_W-1:0]      bad_addr;
        logic [`CPU_ADDR_W-1:0]      pc;
        logic                        in_delay;
    } mem_wb_t;

    typedef struct packed {
        logic                                      valid;
        logic [$clog2(`CPU_TLB_ENTRIES)-1:0]       index;
        logic [`CPU_ADDR_W-`CPU_PAGE_BITS-1:0]     vpn;
        logic [`CPU_ADDR_W-`CPU_PAGE_BITS-1:0]     pfn;
    } tlb_wr_t;

    typedef struct packed {
        logic [`CPU_DATA_W-1:0] status;
        logic [`CPU_DATA_W-1:0] cause;
        logic [`CPU_DATA_W-1:0] epc;
    } cp0_view_t;

endpackage

`default_nettype wire

// ==== logic/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module data_ram (
    input  wire                      clk,
    input  wire                      ce_i,
    input  wire                      we_i,
    input  wire [3:0]                sel_i,
    input  wire [`CPU_ADDR_W-1:0]    addr_i,
    input  wire [`CPU_DATA_W-1:0]    wdata_i,
    output logic [`CPU_DATA_W-1:0]   rdata_o
);

    localparam int IDX_W = $clog2(`CPU_RAM_WORDS);

    logic [`CPU_DATA_W-1:0] mem_q [`CPU_RAM_WORDS];
    logic [IDX_W-1:0]       idx;

    // Word index, byte offset dropped
    assign idx = addr_i[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (ce_i && we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (sel_i[b]) begin
                    mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    assign rdata_o = mem_q[idx];

endmodule

`default_nettype wire

// ==== logic/mem_pipe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module mem_pipe_top (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire cpu_pkg::ex_mem_t      ex_i,
    input  wire cpu_pkg::tlb_wr_t      tlb_wr_i,
    input  wire [`CPU_HW_INT_W-1:0]    hw_int_i,
    output wire cpu_pkg::mem_wb_t      wb_o,
    output wire cpu_pkg::cp0_view_t    cp0_o
);

    wire [`CPU_ADDR_W-1:0] vaddr;
    wire                   tlb_hit;
    wire [`CPU_ADDR_W-1:0] paddr;
    wire                   ram_ce;
    wire                   ram_we;
    wire [3:0]             ram_sel;
    wire [`CPU_ADDR_W-1:0] ram_addr;
    wire [`CPU_DATA_W-1:0] ram_wdata;
    wire [`CPU_DATA_W-1:0] ram_rdata;

    mem_stage stage0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ex_i        (ex_i),
        .cp0_i       (cp0_o),
        .vaddr_o     (vaddr),
        .tlb_hit_i   (tlb_hit),
        .paddr_i     (paddr),
        .ram_ce_o    (ram_ce),
        .ram_we_o    (ram_we),
        .ram_sel_o   (ram_sel),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata),
        .wb_o        (wb_o)
    );

    tlb tlb0 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wr_i    (tlb_wr_i),
        .vaddr_i (vaddr),
        .hit_o   (tlb_hit),
        .paddr_o (paddr)
    );

    data_ram ram0 (
        .clk     (clk),
        .ce_i    (ram_ce),
        .we_i    (ram_we),
        .sel_i   (ram_sel),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    // Writeback result closes the loop into CP0
    cp0_regs cp0_0 (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .hw_int_i (hw_int_i),
        .wb_i     (wb_o),
        .cp0_o    (cp0_o)
    );

endmodule

`default_nettype wire

// ==== logic/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module mem_stage (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire cpu_pkg::ex_mem_t      ex_i,
    input  wire cpu_pkg::cp0_view_t    cp0_i,
    output logic [`CPU_ADDR_W-1:0]     vaddr_o,
    input  wire                        tlb_hit_i,
    input  wire [`CPU_ADDR_W-1:0]      paddr_i,
    output logic                       ram_ce_o,
    output logic                       ram_we_o,
    output logic [3:0]                 ram_sel_o,
    output logic [`CPU_ADDR_W-1:0]     ram_addr_o,
    output logic [`CPU_DATA_W-1:0]     ram_wdata_o,
    input  wire [`CPU_DATA_W-1:0]      ram_rdata_i,
    output cpu_pkg::mem_wb_t           wb_o
);

    cpu_pkg::cp0_view_t  cp0_fwd;
    cpu_pkg::mem_wb_t    wb_d;
    cpu_pkg::exc_code_e  exc_code;
    logic [`CPU_ADDR_W-1:0] bad_addr;
    logic                is_load;
    logic                is_store;
    logic                access;
    logic                int_pending;
    logic                exc_raised;
    logic [1:0]          boff;
    logic [7:0]          rd_byte;
    logic [15:0]         rd_half;
    logic [3:0]          sel;
    logic [`CPU_DATA_W-1:0] load_data;

    assign vaddr_o = ex_i.addr;

    assign is_load  = ex_i.op inside {cpu_pkg::LB, cpu_pkg::LBU, cpu_pkg::LH,
                                      cpu_pkg::LHU, cpu_pkg::LW};
    assign is_store = ex_i.op inside {cpu_pkg::SB, cpu_pkg::SH, cpu_pkg::SW};
    assign access   = ex_i.valid && (is_load || is_store);

    // CP0 as it will be once the write sitting in writeback lands
    always_comb begin
        cp0_fwd = cp0_i;
        if (wb_o.cp0_we && wb_o.exc_code == cpu_pkg::NONE) begin
            case (wb_o.cp0_num)
                `CPU_CP0_STATUS: begin
                    cp0_fwd.status = wb_o.cp0_wdata;
                end
                `CPU_CP0_CAUSE: begin
                    cp0_fwd.cause[9:8]   = wb_o.cp0_wdata[9:8];
                    cp0_fwd.cause[23:22] = wb_o.cp0_wdata[23:22];
                end
                `CPU_CP0_EPC: begin
                    cp0_fwd.epc = wb_o.cp0_wdata;
                end
                default: begin
                end
            endcase
        end
    end

    // Pending and unmasked, EXL clear, IE set
    assign int_pending = ((cp0_fwd.cause[15:8] & cp0_fwd.status[15:8]) != 8'h00)
                         && !cp0_fwd.status[1] && cp0_fwd.status[0];

    always_comb begin
        exc_code = cpu_pkg::NONE;
        bad_addr = '0;
        if (ex_i.valid) begin
            if (int_pending) begin
                exc_code = cpu_pkg::INT;
            end else if (ex_i.exc_flags[cpu_pkg::EXF_SYS]) begin
                exc_code = cpu_pkg::SYS;
            end else if (ex_i.exc_flags[cpu_pkg::EXF_RI]) begin
                exc_code = cpu_pkg::RI;
            end else if (ex_i.exc_flags[cpu_pkg::EXF_TR]) begin
                exc_code = cpu_pkg::TR;
            end else if (ex_i.exc_flags[cpu_pkg::EXF_OV]) begin
                exc_code = cpu_pkg::OV;
            end else if (ex_i.exc_flags[cpu_pkg::EXF_FETCH]) begin
                exc_code = cpu_pkg::ADEL;
                bad_addr = ex_i.pc;
            end else if (access && !tlb_hit_i) begin
                exc_code = cpu_pkg::TLBL;
                bad_addr = ex_i.addr;
            end
        end
    end

    assign exc_raised = (exc_code != cpu_pkg::NONE);

    assign boff    = paddr_i[1:0];
    assign rd_byte = ram_rdata_i[8*boff +: 8];
    assign rd_half = paddr_i[1] ? ram_rdata_i[31:16] : ram_rdata_i[15:0];

    // Lane select, store replication and load extension
    always_comb begin
        sel         = 4'b0000;
        ram_wdata_o = '0;
        load_data   = '0;
        case (ex_i.op)
            cpu_pkg::LB: begin
                sel       = 4'b0001 << boff;
                load_data = {{24{rd_byte[7]}}, rd_byte};
            end
            cpu_pkg::LBU: begin
                sel       = 4'b0001 << boff;
                load_data = {24'h000000, rd_byte};
            end
            cpu_pkg::LH: begin
                if (!boff[0]) begin
                    sel       = paddr_i[1] ? 4'b1100 : 4'b0011;
                    load_data = {{16{rd_half[15]}}, rd_half};
                end
            end
            cpu_pkg::LHU: begin
                if (!boff[0]) begin
                    sel       = paddr_i[1] ? 4'b1100 : 4'b0011;
                    load_data = {16'h0000, rd_half};
                end
            end
            cpu_pkg::LW: begin
                sel       = 4'b1111;
                load_data = ram_rdata_i;
            end
            cpu_pkg::SB: begin
                sel         = 4'b0001 << boff;
                ram_wdata_o = {4{ex_i.store_data[7:0]}};
            end
            cpu_pkg::SH: begin
                if (!boff[0]) begin
                    sel = paddr_i[1] ? 4'b1100 : 4'b0011;
                end
                ram_wdata_o = {2{ex_i.store_data[15:0]}};
            end
            cpu_pkg::SW: begin
                sel         = 4'b1111;
                ram_wdata_o = ex_i.store_data;
            end
            default: begin
            end
        endcase
    end

    assign ram_ce_o   = access;
    assign ram_we_o   = access && is_store && !exc_raised;
    assign ram_sel_o  = access ? sel : 4'b0000;
    assign ram_addr_o = paddr_i;

    always_comb begin
        wb_d.valid     = ex_i.valid;
        wb_d.reg_waddr = ex_i.reg_waddr;
        wb_d.reg_we    = ex_i.valid && ex_i.reg_we && !exc_raised;
        wb_d.reg_wdata = is_load ? load_data : ex_i.reg_wdata;
        wb_d.hi        = ex_i.hi;
        wb_d.lo        = ex_i.lo;
        wb_d.hilo_we   = ex_i.valid && ex_i.hilo_we;
        wb_d.cp0_we    = ex_i.valid && ex_i.cp0_we;
        wb_d.cp0_num   = ex_i.cp0_num;
        wb_d.cp0_wdata = ex_i.cp0_wdata;
        wb_d.exc_code  = exc_code;
        wb_d.bad_addr  = bad_addr;
        wb_d.pc        = ex_i.pc;
        wb_d.in_delay  = ex_i.in_delay;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_o.valid    <= 1'b0;
            wb_o.reg_we   <= 1'b0;
            wb_o.hilo_we  <= 1'b0;
            wb_o.cp0_we   <= 1'b0;
            wb_o.exc_code <= cpu_pkg::NONE;
        end else begin
            wb_o <= wb_d;
        end
    end

endmodule

`default_nettype wire

// ==== logic/tlb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module tlb (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire cpu_pkg::tlb_wr_t       wr_i,
    input  wire [`CPU_ADDR_W-1:0]       vaddr_i,
    output logic                        hit_o,
    output logic [`CPU_ADDR_W-1:0]      paddr_o
);

    localparam int VPN_W = `CPU_ADDR_W - `CPU_PAGE_BITS;

    logic [`CPU_TLB_ENTRIES-1:0] valid_q;
    logic [VPN_W-1:0]            vpn_q [`CPU_TLB_ENTRIES];
    logic [VPN_W-1:0]            pfn_q [`CPU_TLB_ENTRIES];
    logic                        unmapped;

    // kseg0/kseg1 style window, no translation
    assign unmapped = (vaddr_i[`CPU_ADDR_W-1 -: 2] == 2'b10);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (wr_i.valid) begin
            valid_q[wr_i.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i.valid) begin
            vpn_q[wr_i.index] <= wr_i.vpn;
            pfn_q[wr_i.index] <= wr_i.pfn;
        end
    end

    always_comb begin
        hit_o   = 1'b0;
        paddr_o = '0;
        if (unmapped) begin
            hit_o   = 1'b1;
            paddr_o = {3'b000, vaddr_i[`CPU_ADDR_W-4:0]};
        end else begin
            for (int i = 0; i < `CPU_TLB_ENTRIES; i++) begin
                if (valid_q[i] && vpn_q[i] == vaddr_i[`CPU_ADDR_W-1:`CPU_PAGE_BITS]) begin
                    hit_o   = 1'b1;
                    paddr_o = {pfn_q[i], vaddr_i[`CPU_PAGE_BITS-1:0]};
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/mem_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module mem_checker (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire [2:0]                  phase_i,
    input  wire cpu_pkg::ex_mem_t      ex_i,
    input  wire cpu_pkg::tlb_wr_t      tlb_wr_i,
    input  wire [`CPU_HW_INT_W-1:0]    hw_int_i,
    input  wire cpu_pkg::mem_wb_t      wb_i,
    input  wire cpu_pkg::cp0_view_t    cp0_i,
    output int                         errors_o,
    output int                         checks_o
);

    logic [31:0]        sram [`CPU_RAM_WORDS];
    logic               tv [`CPU_TLB_ENTRIES];
    logic [19:0]        tvpn [`CPU_TLB_ENTRIES];
    logic [19:0]        tpfn [`CPU_TLB_ENTRIES];
    cpu_pkg::cp0_view_t scp0;
    cpu_pkg::mem_wb_t   exp_q;
    logic [2:0]         exp_phase;
    int                 errors = 0;
    int                 checks = 0;

    assign errors_o = errors;
    assign checks_o = checks;

    function automatic string phase_name(input logic [2:0] p);
        case (p)
            3'd1: return "unmapped_load_store";
            3'd2: return "tlb_mapped";
            3'd3: return "exec_flags";
            3'd4: return "interrupt";
            3'd5: return "cp0_forward";
            default: return "reset";
        endcase
    endfunction

    // Bit 32 is the hit flag
    function automatic logic [32:0] translate(input logic [31:0] va);
        logic [32:0] res;
        res = '0;
        if (va[31:30] == 2'b10) begin
            res = {1'b1, 3'b000, va[28:0]};
        end else begin
            for (int i = 0; i < `CPU_TLB_ENTRIES; i++) begin
                if (tv[i] && tvpn[i] == va[31:12]) begin
                    res = {1'b1, tpfn[i], va[11:0]};
                end
            end
        end
        return res;
    endfunction

    function automatic cpu_pkg::cp0_view_t forward(input cpu_pkg::cp0_view_t c,
                                                   input cpu_pkg::mem_wb_t w);
        cpu_pkg::cp0_view_t f;
        f = c;
        if (w.valid && w.cp0_we && w.exc_code == cpu_pkg::NONE) begin
            if (w.cp0_num == `CPU_CP0_STATUS) f.status = w.cp0_wdata;
            if (w.cp0_num == `CPU_CP0_EPC) f.epc = w.cp0_wdata;
            if (w.cp0_num == `CPU_CP0_CAUSE) begin
                f.cause[9:8]   = w.cp0_wdata[9:8];
                f.cause[23:22] = w.cp0_wdata[23:22];
            end
        end
        return f;
    endfunction

    function automatic cpu_pkg::cp0_view_t cp0_next(input cpu_pkg::cp0_view_t c,
                                                    input cpu_pkg::mem_wb_t w,
                                                    input logic [5:0] hw);
        cpu_pkg::cp0_view_t n;
        n = forward(c, w);
        if (w.valid && w.exc_code != cpu_pkg::NONE) begin
            n.epc         = w.in_delay ? w.pc - 32'd4 : w.pc;
            n.cause[31]   = w.in_delay;
            n.cause[6:2]  = w.exc_code;
            n.status[1]   = 1'b1;
        end
        n.cause[15:10] = hw;
        return n;
    endfunction

    // Expected writeback result for one operation
    function automatic cpu_pkg::mem_wb_t expect_wb(input cpu_pkg::ex_mem_t ex,
                                                   input cpu_pkg::cp0_view_t c);
        cpu_pkg::mem_wb_t r;
        logic [32:0] tr;
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        logic        mem_op;
        tr = translate(ex.addr);
        w  = sram[tr[9:2]];
        b  = w[8 * tr[1:0] +: 8];
        h  = tr[1] ? w[31:16] : w[15:0];
        mem_op = ex.op inside {cpu_pkg::LB, cpu_pkg::LBU, cpu_pkg::LH, cpu_pkg::LHU,
                               cpu_pkg::LW, cpu_pkg::SB, cpu_pkg::SH, cpu_pkg::SW};
        r = '0;
        r.valid     = ex.valid;
        r.reg_waddr = ex.reg_waddr;
        r.hi        = ex.hi;
        r.lo        = ex.lo;
        r.hilo_we   = ex.hilo_we;
        r.cp0_we    = ex.cp0_we;
        r.cp0_num   = ex.cp0_num;
        r.cp0_wdata = ex.cp0_wdata;
        r.pc        = ex.pc;
        r.in_delay  = ex.in_delay;
        if ((c.cause[15:8] & c.status[15:8]) != 0 && !c.status[1] && c.status[0])
            r.exc_code = cpu_pkg::INT;
        else if (ex.exc_flags[cpu_pkg::EXF_SYS]) r.exc_code = cpu_pkg::SYS;
        else if (ex.exc_flags[cpu_pkg::EXF_RI]) r.exc_code = cpu_pkg::RI;
        else if (ex.exc_flags[cpu_pkg::EXF_TR]) r.exc_code = cpu_pkg::TR;
        else if (ex.exc_flags[cpu_pkg::EXF_OV]) r.exc_code = cpu_pkg::OV;
        else if (ex.exc_flags[cpu_pkg::EXF_FETCH]) begin
            r.exc_code = cpu_pkg::ADEL;
            r.bad_addr = ex.pc;
        end else if (mem_op && !tr[32]) begin
            r.exc_code = cpu_pkg::TLBL;
            r.bad_addr = ex.addr;
        end
        r.reg_we = ex.reg_we && r.exc_code == cpu_pkg::NONE;
        case (ex.op)
            cpu_pkg::LB:  r.reg_wdata = {{24{b[7]}}, b};
            cpu_pkg::LBU: r.reg_wdata = {24'h0, b};
            cpu_pkg::LH:  r.reg_wdata = tr[0] ? 32'h0 : {{16{h[15]}}, h};
            cpu_pkg::LHU: r.reg_wdata = tr[0] ? 32'h0 : {16'h0, h};
            cpu_pkg::LW:  r.reg_wdata = w;
            default:      r.reg_wdata = ex.reg_wdata;
        endcase
        return r;
    endfunction

    task automatic commit_store(input cpu_pkg::ex_mem_t ex, input cpu_pkg::mem_wb_t r);
        logic [32:0] tr;
        tr = translate(ex.addr);
        if (ex.valid && r.exc_code == cpu_pkg::NONE) begin
            case (ex.op)
                cpu_pkg::SB: sram[tr[9:2]][8 * tr[1:0] +: 8] = ex.store_data[7:0];
                cpu_pkg::SH: if (!tr[0]) sram[tr[9:2]][16 * tr[1] +: 16] = ex.store_data[15:0];
                cpu_pkg::SW: sram[tr[9:2]] = ex.store_data;
                default: ;
            endcase
        end
    endtask

    task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s %s: expected %h, actual %h",
                     phase_name(exp_phase), name, exp, act);
        end
    endtask

    always @(posedge clk) begin
        cpu_pkg::mem_wb_t nxt;
        if (!rst_n_i) begin
            scp0  = '0;
            exp_q = '0;
            exp_phase = 3'd0;
            for (int i = 0; i < `CPU_TLB_ENTRIES; i++) tv[i] = 1'b0;
        end else begin
            check_field("valid", exp_q.valid, wb_i.valid);
            if (exp_q.valid) begin
                check_field("exc_code", exp_q.exc_code, wb_i.exc_code);
                check_field("bad_addr", exp_q.bad_addr, wb_i.bad_addr);
                check_field("reg_we", exp_q.reg_we, wb_i.reg_we);
                check_field("reg_waddr", exp_q.reg_waddr, wb_i.reg_waddr);
                if (exp_q.reg_we) check_field("reg_wdata", exp_q.reg_wdata, wb_i.reg_wdata);
                check_field("hilo_we", exp_q.hilo_we, wb_i.hilo_we);
                check_field("hi", exp_q.hi, wb_i.hi);
                check_field("lo", exp_q.lo, wb_i.lo);
                check_field("cp0_we", exp_q.cp0_we, wb_i.cp0_we);
                check_field("cp0_num", exp_q.cp0_num, wb_i.cp0_num);
                check_field("cp0_wdata", exp_q.cp0_wdata, wb_i.cp0_wdata);
                check_field("pc", exp_q.pc, wb_i.pc);
                check_field("in_delay", exp_q.in_delay, wb_i.in_delay);
            end
            check_field("cp0_status", scp0.status, cp0_i.status);
            check_field("cp0_cause", scp0.cause, cp0_i.cause);
            check_field("cp0_epc", scp0.epc, cp0_i.epc);
            nxt = expect_wb(ex_i, forward(scp0, exp_q));
            commit_store(ex_i, nxt);
            scp0 = cp0_next(scp0, exp_q, hw_int_i);
            if (tlb_wr_i.valid) begin
                tv[tlb_wr_i.index]   = 1'b1;
                tvpn[tlb_wr_i.index] = tlb_wr_i.vpn;
                tpfn[tlb_wr_i.index] = tlb_wr_i.pfn;
            end
            exp_q = nxt;
            exp_phase = phase_i;
        end
    end

endmodule

`default_nettype wire

// ==== sim/mem_pipe_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_pipe_assert (
    input wire       clk,
    input wire       rst_n_i,
    input wire       ram_we,
    input wire       ex_valid,
    input wire [5:0] exc_flags,
    input wire       int_pending,
    input wire       tlb_hit,
    input wire       access,
    input wire [3:0] sel,
    input wire [3:0] op,
    input wire [1:0] boff,
    input wire       wb_valid
);

    int   fail_count = 0;
    logic aligned;
    logic exc_source;

    assign aligned = (op inside {cpu_pkg::LB, cpu_pkg::LBU, cpu_pkg::SB,
                                 cpu_pkg::LW, cpu_pkg::SW})
                     || (op inside {cpu_pkg::LH, cpu_pkg::LHU, cpu_pkg::SH} && !boff[0]);

    // Any cause that has to rank as an exception
    assign exc_source = ex_valid
                        && (int_pending
                            || exc_flags[cpu_pkg::EXF_SYS] || exc_flags[cpu_pkg::EXF_RI]
                            || exc_flags[cpu_pkg::EXF_TR] || exc_flags[cpu_pkg::EXF_OV]
                            || exc_flags[cpu_pkg::EXF_FETCH] || (access && !tlb_hit));

    no_store_on_exc: assert property (@(posedge clk) disable iff (!rst_n_i)
        exc_source |-> !ram_we)
        else begin
            $error("RAM write enable high while an exception is raised");
            fail_count++;
        end

    sel_on_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        (access && aligned) |-> (sel != 4'b0000))
        else begin
            $error("Byte select is zero on an aligned access");
            fail_count++;
        end

    no_valid_in_reset: assert property (@(posedge clk) !rst_n_i |=> !wb_valid)
        else begin
            $error("Writeback valid during reset");
            fail_count++;
        end

endmodule

bind mem_stage mem_pipe_assert asrt0 (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .ram_we      (ram_we_o),
    .ex_valid    (ex_i.valid),
    .exc_flags   (ex_i.exc_flags),
    .int_pending (int_pending),
    .tlb_hit     (tlb_hit_i),
    .access      (access),
    .sel         (ram_sel_o),
    .op          (ex_i.op),
    .boff        (paddr_i[1:0]),
    .wb_valid    (wb_o.valid)
);

`default_nettype wire

// ==== sim/tb_mem_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module tb_mem_pipe;

    localparam int FILL_OPS  = 16;
    localparam int RAND_OPS  = 60;
    localparam int MAP_OPS   = 30;
    localparam int FLAG_OPS  = 20;
    localparam int CP0_OPS   = 10;
    localparam int RUN_LIMIT = 2 + FILL_OPS + RAND_OPS + 1 + MAP_OPS + FLAG_OPS + CP0_OPS + 4 + 50;

    logic                   clk;
    logic                   rst_n;
    cpu_pkg::ex_mem_t       ex;
    cpu_pkg::tlb_wr_t       tlb_wr;
    logic [`CPU_HW_INT_W-1:0] hw_int;
    cpu_pkg::mem_wb_t       wb;
    cpu_pkg::cp0_view_t     cp0;
    logic [2:0]             phase;
    logic [31:0]            rng;
    int                     errors;
    int                     checks;
    int                     total_errors;
    int                     cycles = 0;

    always #10 clk = ~clk;

    mem_pipe_top dut0 (
        .clk      (clk),
        .rst_n_i  (rst_n),
        .ex_i     (ex),
        .tlb_wr_i (tlb_wr),
        .hw_int_i (hw_int),
        .wb_o     (wb),
        .cp0_o    (cp0)
    );

    mem_checker chk0 (
        .clk      (clk),
        .rst_n_i  (rst_n),
        .phase_i  (phase),
        .ex_i     (ex),
        .tlb_wr_i (tlb_wr),
        .hw_int_i (hw_int),
        .wb_i     (wb),
        .cp0_i    (cp0),
        .errors_o (errors),
        .checks_o (checks)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles >= RUN_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", RUN_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] v);
        rng = xorshift32(rng);
        v = rng;
    endtask

    // One memory operation with random side fields
    task automatic drive_op(input cpu_pkg::mem_op_e op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [5:0] flags);
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        next_rand(r0);
        next_rand(r1);
        next_rand(r2);
        next_rand(r3);
        @(negedge clk);
        tlb_wr       = '0;
        ex           = '0;
        ex.valid     = 1'b1;
        ex.reg_waddr = r0[4:0];
        ex.reg_we    = r0[5];
        ex.reg_wdata = r1;
        ex.hi        = r2;
        ex.lo        = r3;
        ex.hilo_we   = r0[6];
        ex.op        = op;
        ex.addr      = addr;
        ex.store_data = data;
        ex.exc_flags = flags;
        ex.in_delay  = r0[7];
        ex.pc        = {r3[31:2] ^ r1[29:0], 2'b00};
    endtask

    task automatic drive_cp0_write(input logic [4:0] num, input logic [31:0] data);
        drive_op(cpu_pkg::NOP, 32'h0, 32'h0, 6'h00);
        ex.cp0_we    = 1'b1;
        ex.cp0_num   = num;
        ex.cp0_wdata = data;
    endtask

    task automatic drive_random(input logic [31:0] page, input logic [5:0] flags);
        logic [31:0] r;
        logic [31:0] d;
        cpu_pkg::mem_op_e op;
        next_rand(r);
        next_rand(d);
        op = cpu_pkg::mem_op_e'(4'(1 + r[15:8] % 8));
        drive_op(op, page | {26'h0, r[5:0]}, d, flags);
    endtask

    initial begin
        logic [31:0] r;
        clk    = 1'b0;
        rst_n  = 1'b0;
        ex     = '0;
        tlb_wr = '0;
        hw_int = '0;
        phase  = 3'd0;
        rng    = 32'd94559;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // Fill the test window so every later load reads known data
        phase = 3'd1;
        for (int i = 0; i < FILL_OPS; i++) begin
            next_rand(r);
            drive_op(cpu_pkg::SW, 32'h8000_0000 + 4 * i, r, 6'h00);
        end
        for (int i = 0; i < RAND_OPS; i++) begin
            drive_random(32'h8000_0000, 6'h00);
        end

        phase = 3'd2;
        @(negedge clk);
        ex     = '0;
        tlb_wr = '{valid: 1'b1, index: 3'd3, vpn: 20'h00010, pfn: 20'h00000};
        for (int i = 0; i < MAP_OPS; i++) begin
            next_rand(r);
            drive_random(r[31] ? 32'h0001_0000 : 32'h0002_0000, 6'h00);
        end

        // Every fourth op carries a bare fetch address error
        phase = 3'd3;
        for (int i = 0; i < FLAG_OPS; i++) begin
            next_rand(r);
            drive_random(32'h8000_0000, (i % 4 == 3) ? 6'b100000 : r[5:0]);
        end

        phase = 3'd4;
        hw_int = 6'b000001;
        drive_cp0_write(`CPU_CP0_STATUS, 32'h0000_FF01);
        for (int i = 0; i < 3; i++) begin
            drive_random(32'h8000_0000, 6'h00);
        end

        // Mask cleared, then one line unmasked right before the next op
        phase = 3'd5;
        drive_cp0_write(`CPU_CP0_STATUS, 32'h0000_0001);
        drive_random(32'h8000_0000, 6'h00);
        drive_cp0_write(`CPU_CP0_STATUS, 32'h0000_0401);
        drive_random(32'h8000_0000, 6'h00);
        hw_int = 6'b000000;
        drive_cp0_write(`CPU_CP0_STATUS, 32'h0000_0000);
        drive_random(32'h8000_0000, 6'h00);

        @(negedge clk);
        ex     = '0;
        tlb_wr = '0;
        repeat (3) @(negedge clk);

        total_errors = errors + dut0.stage0.asrt0.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut0.stage0.asrt0.fail_count);
        if (total_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/tlb.sv
logic/data_ram.sv
logic/cp0_regs.sv
logic/mem_stage.sv
logic/mem_pipe_top.sv
sim/mem_pipe_assert.sv
sim/mem_checker.sv
sim/tb_mem_pipe.sv
